// ==== all.f ====
design/fdc_cmd_pkg.sv
design/fdc_disk_pkg.sv
design/fdc_cmd_phase.sv
design/fdc_drive_unit.sv
design/fdc_status_merge.sv
design/fdc_top.sv
verif/fdc_assert.sv
verif/fdc_tb.sv

// ==== design/fdc_cmd_phase.sv ====
`timescale 1ns/1ps

module fdc_cmd_phase
  import fdc_cmd_pkg::*;
  import fdc_disk_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ce,
  input  logic                  a0,
  input  logic                  rd_n,
  input  logic                  wr_n,
  input  logic                  motorctl,
  input  logic [7:0]            din,
  input  logic                  result_last,
  input  logic [num_drives-1:0] int_pending,
  output logic [1:0]            phase,
  output logic                  motor_on,
  output logic [num_drives-1:0] seek_go,
  output logic [cyl_w-1:0]      seek_cyl,
  output logic [num_drives-1:0] rdy_sample,
  output logic [num_drives-1:0] int_take,
  output logic                  load_invalid,
  output logic                  load_sense_int,
  output logic                  load_drive_status,
  output logic                  status_unit,
  output logic                  result_advance
);

  logic       prev_rd_n;
  logic       prev_wr_n;
  logic       rd_pending;
  logic [4:0] op_q;
  logic [3:0] param_cnt;
  logic [3:0] param_need;
  logic       drsel;
  logic       wr_stb;
  logic       wr_cmd;
  logic       rd_start;
  logic       rd_done;
  logic       last_param;

  // strobes from sampled bus levels
  assign wr_stb   = prev_wr_n & ~wr_n;
  assign rd_start = prev_rd_n & ~rd_n;
  assign rd_done  = ~prev_rd_n & rd_n;
  // motor writes take priority over the data port
  assign wr_cmd   = wr_stb & ~motorctl & ce & a0;

  assign last_param     = (param_cnt + 4'd1) == param_need;
  // only data port reads in rx move the result pointer
  assign result_advance = rd_done & rd_pending;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prev_rd_n  <= 1'b1;
      prev_wr_n  <= 1'b1;
      rd_pending <= 1'b0;
      phase      <= phase_idle;
      motor_on   <= 1'b0;
      param_cnt  <= 4'd0;
    end else begin
      prev_rd_n <= rd_n;
      prev_wr_n <= wr_n;
      if (rd_start) begin
        rd_pending <= ce & a0 & (phase == phase_rx);
      end else if (rd_done) begin
        rd_pending <= 1'b0;
      end
      // last result byte read
      if (result_advance && result_last) begin
        phase <= phase_idle;
      end
      if (wr_stb && motorctl) begin
        motor_on <= din[0];
      end else if (wr_cmd && phase == phase_idle) begin
        param_cnt <= 4'd0;
        case (din[4:0])
          op_specify, op_seek, op_recalibrate, op_sense_drive_status: phase <= phase_cmd;
          // sense int and invalid answer at once
          default: phase <= phase_rx;
        endcase
      end else if (wr_cmd && phase == phase_cmd) begin
        param_cnt <= param_cnt + 4'd1;
        if (last_param) begin
          // only drive status has a result
          phase <= (op_q == op_sense_drive_status) ? phase_rx : phase_idle;
        end
      end
    end
  end

  // opcode, its parameter count and the selected drive
  always_ff @(posedge clk) begin
    if (wr_cmd && phase == phase_idle) begin
      op_q <= din[4:0];
      case (din[4:0])
        op_specify:            param_need <= params_specify;
        op_seek:               param_need <= params_seek;
        op_recalibrate:        param_need <= params_recal;
        op_sense_drive_status: param_need <= params_drive_status;
        default:               param_need <= 4'd0;
      endcase
    end
    if (wr_cmd && phase == phase_cmd && param_cnt == 4'd0) begin
      drsel <= din[0];
    end
  end

  always_comb begin
    seek_go           = '0;
    rdy_sample        = '0;
    int_take          = '0;
    load_invalid      = 1'b0;
    load_sense_int    = 1'b0;
    load_drive_status = 1'b0;
    status_unit       = din[0];
    // recalibrate heads for track 0
    seek_cyl          = (op_q == op_recalibrate) ? '0 : din[cyl_w-1:0];
    if (wr_cmd && phase == phase_idle) begin
      case (din[4:0])
        op_specify, op_seek, op_recalibrate, op_sense_drive_status: ;
        op_sense_int_status: begin
          // lowest pending drive wins
          load_sense_int = 1'b1;
          int_take[0]    = int_pending[0];
          int_take[1]    = int_pending[1] & ~int_pending[0];
          status_unit    = ~int_pending[0];
        end
        default: load_invalid = 1'b1;
      endcase
    end else if (wr_cmd && phase == phase_cmd) begin
      // ready latched on every parameter byte
      rdy_sample[din[0]] = 1'b1;
      if (last_param) begin
        case (op_q)
          op_seek:               seek_go[drsel] = 1'b1;
          op_recalibrate:        seek_go[din[0]] = 1'b1;
          op_sense_drive_status: load_drive_status = 1'b1;
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== design/fdc_cmd_pkg.sv ====
package fdc_cmd_pkg;

  // command opcodes, low five bits of the command byte
  localparam logic [4:0] op_specify            = 5'h03;
  localparam logic [4:0] op_sense_drive_status = 5'h04;
  localparam logic [4:0] op_recalibrate        = 5'h07;
  localparam logic [4:0] op_sense_int_status   = 5'h08;
  localparam logic [4:0] op_seek               = 5'h0f;

  // host bus phases
  localparam logic [1:0] phase_idle = 2'd0;
  localparam logic [1:0] phase_cmd  = 2'd1;
  localparam logic [1:0] phase_rx   = 2'd2;

  // parameter bytes per command
  localparam logic [3:0] params_specify      = 4'd2;
  // drive select, then new cylinder
  localparam logic [3:0] params_seek         = 4'd2;
  localparam logic [3:0] params_recal        = 4'd1;
  localparam logic [3:0] params_drive_status = 4'd1;

  // main status register bits
  // request for master
  localparam int msr_rfm  = 7;
  // data direction, set when bytes go to the host
  localparam int msr_dio  = 6;
  // command in progress
  localparam int msr_busy = 4;

  // st0 for a rejected command or an empty interrupt query
  localparam logic [7:0] res_invalid = 8'h80;

  // longest result, st0 plus present cylinder
  localparam logic [1:0] max_results = 2'd2;

  // value on dout when nothing is read
  localparam logic [7:0] bus_idle_byte = 8'hff;

endpackage

// ==== design/fdc_disk_pkg.sv ====
package fdc_disk_pkg;

  // drives behind the controller
  localparam int num_drives = 2;
  // present cylinder width
  localparam int cyl_w      = 7;

  // request word to the disk emulator
  // target cylinder field
  localparam int sr_cyl_lo = 8;
  localparam int sr_cyl_hi = 14;
  // set once a seek has been seen complete
  localparam int sr_ack    = 23;
  // per drive seek request levels
  localparam int sr_seek0  = 30;
  localparam int sr_seek1  = 31;

  // completion word from the disk emulator
  // per drive seek done levels
  localparam int cr_seekdone0 = 0;
  localparam int cr_seekdone1 = 1;
  // seek failed
  localparam int cr_error     = 3;
  // disk present per drive
  localparam int cr_diskin0   = 5;
  localparam int cr_diskin1   = 6;

endpackage

// ==== design/fdc_drive_unit.sv ====
`timescale 1ns/1ps

module fdc_drive_unit
  import fdc_disk_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             seek_go,
  input  logic [cyl_w-1:0] seek_cyl,
  input  logic             rdy_sample,
  input  logic             int_take,
  input  logic             motor_on,
  input  logic             seek_done_in,
  input  logic             disk_error,
  input  logic             disk_in,
  output logic             busy,
  output logic             seek_req,
  output logic             seek_done,
  output logic             int_pending,
  output logic             int_error,
  output logic [cyl_w-1:0] cylinder,
  output logic             rdy
);

  logic seeking;
  logic complete;

  // emulator finished this drive's seek
  assign complete = seeking & seek_done_in;

  // request level doubles as the drive busy bit
  assign busy     = seeking;
  assign seek_req = seeking;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seeking   <= 1'b0;
      seek_done <= 1'b0;
    end else begin
      // one cycle after completion, for the ack bit
      seek_done <= complete;
      // a new seek beats a completion on the same clock
      if (seek_go) begin
        seeking <= 1'b1;
      end else if (complete) begin
        seeking <= 1'b0;
      end
    end
  end

  // cylinder taken at seek start, not at completion
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cylinder <= '0;
    end else if (seek_go) begin
      cylinder <= seek_cyl;
    end
  end

  // interrupt held until sense int status takes it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      int_pending <= 1'b0;
      int_error   <= 1'b0;
    end else if (complete) begin
      int_pending <= 1'b1;
      int_error   <= disk_error;
    end else if (int_take) begin
      int_pending <= 1'b0;
      int_error   <= 1'b0;
    end
  end

  // ready needs motor and a disk
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdy <= 1'b0;
    end else if (rdy_sample) begin
      rdy <= motor_on & disk_in;
    end
  end

endmodule

// ==== design/fdc_status_merge.sv ====
`timescale 1ns/1ps

module fdc_status_merge
  import fdc_cmd_pkg::*;
  import fdc_disk_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        ce,
  input  logic                        a0,
  input  logic                        rd_n,
  input  logic [1:0]                  phase,
  input  logic                        load_invalid,
  input  logic                        load_sense_int,
  input  logic                        load_drive_status,
  input  logic                        status_unit,
  input  logic [num_drives-1:0]       int_take,
  input  logic                        result_advance,
  input  logic [num_drives-1:0]       busy,
  input  logic [num_drives-1:0]       seek_req,
  input  logic [num_drives-1:0]       seek_go,
  input  logic [num_drives-1:0]       seek_done,
  input  logic [num_drives-1:0]       int_error,
  input  logic [num_drives*cyl_w-1:0] cylinder,
  input  logic [num_drives-1:0]       rdy,
  input  logic [31:0]                 disk_cr,
  input  logic [num_drives-1:0]       disk_wp,
  input  logic [cyl_w-1:0]            seek_cyl,
  output logic [7:0]                  dout,
  output logic [31:0]                 disk_sr,
  output logic                        result_last
);

  logic [7:0]       msr;
  logic [7:0]       res_buf [0:1];
  logic [1:0]       res_len;
  logic             res_ptr;
  logic [cyl_w-1:0] sr_cyl;
  logic             ack;
  logic [cyl_w-1:0] cyl_sel;
  logic             err_sel;
  logic             not_ready;

  // fields of the addressed drive
  assign cyl_sel   = cylinder[status_unit*cyl_w +: cyl_w];
  assign err_sel   = int_error[status_unit];
  assign not_ready = status_unit ? ~disk_cr[cr_diskin1] : ~disk_cr[cr_diskin0];

  always_comb begin
    msr = 8'h00;
    // host may not write while a seek runs from idle
    msr[msr_rfm]  = (phase == phase_idle) ? ~(|busy) : 1'b1;
    msr[msr_dio]  = phase == phase_rx;
    msr[msr_busy] = phase != phase_idle;
    msr[num_drives-1:0] = busy;
  end

  always_comb begin
    disk_sr = 32'h0;
    disk_sr[sr_seek0] = seek_req[0];
    disk_sr[sr_seek1] = seek_req[1];
    disk_sr[sr_cyl_hi:sr_cyl_lo] = sr_cyl;
    disk_sr[sr_ack] = ack;
  end

  // target cylinder and ack toward the emulator
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sr_cyl <= '0;
      ack    <= 1'b0;
    end else if (|seek_go) begin
      sr_cyl <= seek_cyl;
      ack    <= 1'b0;
    end else if (|seek_done) begin
      ack <= 1'b1;
    end
  end

  // result bytes
  always_ff @(posedge clk) begin
    if (load_invalid) begin
      res_buf[0] <= res_invalid;
    end else if (load_sense_int && |int_take) begin
      // st0 then present cylinder
      res_buf[0] <= {1'b0, err_sel, ~err_sel, 1'b0, not_ready, 2'b00, status_unit};
      res_buf[1] <= {1'b0, cyl_sel};
    end else if (load_sense_int) begin
      res_buf[0] <= res_invalid;
    end else if (load_drive_status) begin
      // st3 with ready as latched before this byte
      res_buf[0] <= {1'b0, disk_wp[status_unit], rdy[status_unit], cyl_sel == '0,
                     3'b000, status_unit};
    end
  end

  // result length and read pointer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_len <= 2'd0;
      res_ptr <= 1'b0;
    end else if (load_invalid || load_sense_int || load_drive_status) begin
      res_len <= (load_sense_int && |int_take) ? max_results : 2'd1;
      res_ptr <= 1'b0;
    end else if (result_advance) begin
      res_ptr <= result_last ? 1'b0 : res_ptr + 1'b1;
    end
  end

  assign result_last = ({1'b0, res_ptr} + 2'd1) == res_len;

  // a0 low reads status, a0 high reads results in rx
  always_comb begin
    dout = bus_idle_byte;
    if (ce && !rd_n) begin
      if (!a0) begin
        dout = msr;
      end else if (phase == phase_rx) begin
        dout = res_buf[res_ptr];
      end
    end
  end

endmodule

// ==== design/fdc_top.sv ====
`timescale 1ns/1ps

module fdc_top
  import fdc_disk_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        ce,
  input  logic        a0,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        motorctl,
  input  logic [7:0]  din,
  output logic [7:0]  dout,
  input  logic [31:0] disk_cr,
  input  logic [1:0]  disk_wp,
  output logic [31:0] disk_sr
);

  logic [1:0]                  phase;
  logic                        motor_on;
  logic [num_drives-1:0]       seek_go;
  logic [cyl_w-1:0]            seek_cyl;
  logic [num_drives-1:0]       rdy_sample;
  logic [num_drives-1:0]       int_take;
  logic                        load_invalid;
  logic                        load_sense_int;
  logic                        load_drive_status;
  logic                        status_unit;
  logic                        result_advance;
  logic                        result_last;
  logic [num_drives-1:0]       busy;
  logic [num_drives-1:0]       seek_req;
  logic [num_drives-1:0]       seek_done;
  logic [num_drives-1:0]       int_pending;
  logic [num_drives-1:0]       int_error;
  logic [num_drives*cyl_w-1:0] cylinder;
  logic [num_drives-1:0]       rdy;

  // per drive bits of the completion word
  wire [num_drives-1:0] cr_seekdone = {disk_cr[cr_seekdone1], disk_cr[cr_seekdone0]};
  wire [num_drives-1:0] cr_diskin   = {disk_cr[cr_diskin1], disk_cr[cr_diskin0]};

  fdc_cmd_phase u_cmd_phase (
    .clk, .rst_n, .ce, .a0, .rd_n, .wr_n, .motorctl, .din,
    .result_last, .int_pending,
    .phase, .motor_on, .seek_go, .seek_cyl, .rdy_sample, .int_take,
    .load_invalid, .load_sense_int, .load_drive_status, .status_unit,
    .result_advance
  );

  // one unit per drive, error shared by both
  for (genvar i = 0; i < num_drives; i++) begin : g_drive
    fdc_drive_unit u_drive (
      .clk, .rst_n,
      .seek_go      (seek_go[i]),
      .seek_cyl     (seek_cyl),
      .rdy_sample   (rdy_sample[i]),
      .int_take     (int_take[i]),
      .motor_on     (motor_on),
      .seek_done_in (cr_seekdone[i]),
      .disk_error   (disk_cr[cr_error]),
      .disk_in      (cr_diskin[i]),
      .busy         (busy[i]),
      .seek_req     (seek_req[i]),
      .seek_done    (seek_done[i]),
      .int_pending  (int_pending[i]),
      .int_error    (int_error[i]),
      .cylinder     (cylinder[i*cyl_w +: cyl_w]),
      .rdy          (rdy[i])
    );
  end

  fdc_status_merge u_status_merge (
    .clk, .rst_n, .ce, .a0, .rd_n, .phase,
    .load_invalid, .load_sense_int, .load_drive_status, .status_unit,
    .int_take, .result_advance, .busy, .seek_req, .seek_go, .seek_done,
    .int_error, .cylinder, .rdy, .disk_cr, .disk_wp, .seek_cyl,
    .dout, .disk_sr, .result_last
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the fdc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module fdc_tb -o fdc_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/fdc_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
  exit 0
else
  exit 1
fi

// ==== verif/fdc_assert.sv ====
`timescale 1ns/1ps

module fdc_assert
  import fdc_cmd_pkg::*;
  import fdc_disk_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        ce,
  input logic        a0,
  input logic        rd_n,
  input logic [7:0]  dout,
  input logic [31:0] disk_sr
);

  // emulator serves one seek at a time
  a_one_seek: assert property (@(posedge clk) disable iff (!rst_n)
    !(disk_sr[sr_seek0] && disk_sr[sr_seek1]))
    else $error("both seek requests raised together");

  // bus floats high without chip enable
  a_idle_bus: assert property (@(posedge clk) disable iff (!rst_n)
    !ce |-> dout == bus_idle_byte)
    else $error("dout driven while ce is low");

  // request level shows as drive busy in a status read
  a_busy0: assert property (@(posedge clk) disable iff (!rst_n)
    (ce && !rd_n && !a0 && disk_sr[sr_seek0]) |-> dout[0])
    else $error("drive 0 seeking but not busy in status");

  a_busy1: assert property (@(posedge clk) disable iff (!rst_n)
    (ce && !rd_n && !a0 && disk_sr[sr_seek1]) |-> dout[1])
    else $error("drive 1 seeking but not busy in status");

endmodule

bind fdc_top fdc_assert assert_i (.clk, .rst_n, .ce, .a0, .rd_n, .dout, .disk_sr);

// ==== verif/fdc_tb.sv ====
`timescale 1ns/1ps

module fdc_tb
  import fdc_cmd_pkg::*;
  import fdc_disk_pkg::*;
();

  // five tests of under 300 cycles each
  localparam int max_cycles = 2000;

  logic        clk;
  logic        rst_n;
  logic        ce;
  logic        a0;
  logic        rd_n;
  logic        wr_n;
  logic        motorctl;
  logic [7:0]  din;
  logic [7:0]  dout;
  logic [31:0] disk_cr;
  logic [1:0]  disk_wp;
  logic [31:0] disk_sr;
  // pieces of the completion word
  logic [1:0]  emu_done;
  logic        disk_err;
  logic [1:0]  disk_in;
  // expected drive state
  logic        model_motor;
  logic [1:0]  model_rdy;
  logic [6:0]  model_cyl [0:1];
  int          cycles;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_passed;

  fdc_top dut_i (
    .clk, .rst_n, .ce, .a0, .rd_n, .wr_n, .motorctl, .din, .dout,
    .disk_cr, .disk_wp, .disk_sr
  );

  always_comb begin
    disk_cr = 32'h0;
    disk_cr[cr_seekdone0] = emu_done[0];
    disk_cr[cr_seekdone1] = emu_done[1];
    disk_cr[cr_error]     = disk_err;
    disk_cr[cr_diskin0]   = disk_in[0];
    disk_cr[cr_diskin1]   = disk_in[1];
  end

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // disk emulator serving one seek at a time after a random delay
  initial begin : disk_emulator
    int   delay;
    int   req_bit;
    logic unit;
    emu_done = 2'b00;
    forever begin
      @(posedge clk);
      #10;
      if (disk_sr[sr_seek0] || disk_sr[sr_seek1]) begin
        unit    = disk_sr[sr_seek1];
        req_bit = unit ? sr_seek1 : sr_seek0;
        delay   = $urandom_range(20, 1);
        repeat (delay) begin
          @(posedge clk);
          #10;
        end
        emu_done[unit] = 1'b1;
        // done held until the request drops
        while (disk_sr[req_bit]) begin
          @(posedge clk);
          #10;
        end
        emu_done[unit] = 1'b0;
      end
    end
  end

  // run limit
  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the DUT stopped answering", cycles);
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [7:0] expected_msr(input logic [1:0] ph, input logic [1:0] busy_v);
    logic [7:0] m;
    m = 8'h00;
    // no new command while a drive seeks from idle
    m[msr_rfm]  = (ph == phase_idle) ? (busy_v == 2'b00) : 1'b1;
    m[msr_dio]  = (ph == phase_rx);
    m[msr_busy] = (ph != phase_idle);
    m[1:0]      = busy_v;
    return m;
  endfunction

  function automatic logic [7:0] expected_st0(input logic err, input logic present,
                                              input logic unit);
    logic [7:0] m;
    m = 8'h00;
    // abnormal end on error, seek end otherwise
    if (err) m[6] = 1'b1;
    else m[5] = 1'b1;
    if (!present) m[3] = 1'b1;
    m[0] = unit;
    return m;
  endfunction

  function automatic logic [7:0] expected_st3(input logic wp, input logic ready,
                                              input logic trk0, input logic unit);
    return {1'b0, wp, ready, trk0, 3'b000, unit};
  endfunction

  function automatic logic [31:0] request_word(input logic [1:0] seeks, input logic [6:0] cyl,
                                               input logic ack);
    logic [31:0] w;
    w = 32'h0;
    w[sr_seek0] = seeks[0];
    w[sr_seek1] = seeks[1];
    w[sr_cyl_hi:sr_cyl_lo] = cyl;
    w[sr_ack] = ack;
    return w;
  endfunction

  task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  // strobe taken at the next edge
  task automatic bus_write(input logic port, input logic mctl, input logic [7:0] data);
    ce       = ~mctl;
    a0       = port;
    motorctl = mctl;
    din      = data;
    wr_n     = 1'b0;
    @(posedge clk);
    #10;
    wr_n     = 1'b1;
    ce       = 1'b0;
    motorctl = 1'b0;
    @(posedge clk);
    #10;
  endtask

  // dout sampled mid cycle and the read completes when rd_n rises
  task automatic bus_read(input logic port, output logic [7:0] data);
    ce   = 1'b1;
    a0   = port;
    rd_n = 1'b0;
    @(negedge clk);
    data = dout;
    @(posedge clk);
    #10;
    rd_n = 1'b1;
    ce   = 1'b0;
    @(posedge clk);
    #10;
  endtask

  task automatic write_cmd(input logic [7:0] data);
    bus_write(1'b1, 1'b0, data);
  endtask

  // every parameter byte latches ready of the drive in bit 0
  task automatic write_param(input logic [7:0] data);
    model_rdy[data[0]] = model_motor & disk_in[data[0]];
    bus_write(1'b1, 1'b0, data);
  endtask

  task automatic write_motor(input logic on);
    model_motor = on;
    bus_write(1'b0, 1'b1, {7'b0000000, on});
  endtask

  task automatic check_status(input logic [1:0] ph, input logic [1:0] busy_v, input string what);
    logic [7:0] got;
    bus_read(1'b0, got);
    compare_byte(got, expected_msr(ph, busy_v), what);
  endtask

  task automatic check_result(input logic [7:0] exp, input string what);
    logic [7:0] got;
    bus_read(1'b1, got);
    compare_byte(got, exp, what);
  endtask

  task automatic wait_seek_ack();
    while (!disk_sr[sr_ack]) begin
      @(posedge clk);
      #10;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      $display("%s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic invalid_opcode();
    int errs_before;
    errs_before = errors;
    // low field 0 is no known command
    write_cmd(8'h00);
    check_status(phase_rx, 2'b00, "status after invalid opcode");
    check_result(8'h80, "invalid opcode st0");
    check_status(phase_idle, 2'b00, "status after result read");
    finish_test("invalid opcode", errs_before);
  endtask

  task automatic specify_then_empty_sense();
    int errs_before;
    errs_before = errors;
    write_cmd({3'b000, op_specify});
    check_status(phase_cmd, 2'b00, "status in specify");
    write_param(8'haf);
    write_param(8'h02);
    check_status(phase_idle, 2'b00, "status after specify");
    write_cmd({3'b000, op_sense_int_status});
    check_status(phase_rx, 2'b00, "status after empty sense int");
    check_result(8'h80, "empty sense int st0");
    check_status(phase_idle, 2'b00, "status after empty sense int read");
    finish_test("specify and empty sense int", errs_before);
  endtask

  task automatic seek_drive1();
    int         errs_before;
    int         rnd;
    logic [6:0] cyl;
    errs_before = errors;
    rnd = $urandom_range(127, 0);
    cyl = rnd[6:0];
    write_cmd({3'b000, op_seek});
    write_param(8'h01);
    write_param({1'b0, cyl});
    model_cyl[1] = cyl;
    compare_word(disk_sr, request_word(2'b10, cyl, 1'b0), "request word during seek");
    check_status(phase_idle, 2'b10, "status during seek");
    wait_seek_ack();
    compare_word(disk_sr, request_word(2'b00, cyl, 1'b1), "request word after seek");
    write_cmd({3'b000, op_sense_int_status});
    check_status(phase_rx, 2'b00, "status after sense int");
    check_result(expected_st0(1'b0, disk_in[1], 1'b1), "seek st0");
    check_result({1'b0, cyl}, "seek cylinder");
    check_status(phase_idle, 2'b00, "status after sense int read");
    finish_test("seek drive 1", errs_before);
  endtask

  task automatic recalibrate_with_error();
    int errs_before;
    errs_before = errors;
    disk_err = 1'b1;
    disk_in  = 2'b01;
    write_cmd({3'b000, op_recalibrate});
    // drive 0 with the head bit set in the upper bits
    write_param(8'h04);
    model_cyl[0] = 7'd0;
    compare_word(disk_sr, request_word(2'b01, 7'd0, 1'b0), "request word during recal");
    check_status(phase_idle, 2'b01, "status during recal");
    wait_seek_ack();
    write_cmd({3'b000, op_sense_int_status});
    check_result(expected_st0(1'b1, disk_in[0], 1'b0), "recal st0");
    check_result(8'h00, "recal cylinder");
    check_status(phase_idle, 2'b00, "status after recal sense int");
    disk_err = 1'b0;
    finish_test("recalibrate with error", errs_before);
  endtask

  task automatic sense_drive_status();
    int         errs_before;
    logic       u;
    logic [7:0] st3;
    errs_before = errors;
    write_motor(1'b1);
    disk_in = 2'b11;
    disk_wp = 2'b11;
    // each drive twice so the first query latches ready for the second
    for (int i = 0; i < 4; i++) begin
      u   = (i < 2);
      st3 = expected_st3(disk_wp[u], model_rdy[u], model_cyl[u] == 7'd0, u);
      write_cmd({3'b000, op_sense_drive_status});
      write_param({7'b0000000, u});
      check_status(phase_rx, 2'b00, "status before st3 read");
      check_result(st3, "st3");
      check_status(phase_idle, 2'b00, "status after st3 read");
    end
    finish_test("sense drive status", errs_before);
  endtask

  initial begin
    void'($urandom(33777));
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_passed = 0;
    rst_n        = 1'b0;
    ce           = 1'b0;
    a0           = 1'b0;
    rd_n         = 1'b1;
    wr_n         = 1'b1;
    motorctl     = 1'b0;
    din          = 8'h00;
    disk_wp      = 2'b00;
    disk_err     = 1'b0;
    disk_in      = 2'b00;
    model_motor  = 1'b0;
    model_rdy    = 2'b00;
    model_cyl[0] = 7'd0;
    model_cyl[1] = 7'd0;
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;
    invalid_opcode();
    specify_then_empty_sense();
    seek_drive1();
    recalibrate_with_error();
    sense_drive_status();
    $display("tests %0d, passed %0d, checks %0d, errors %0d",
             tests_run, tests_passed, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
